/* bench/matmul_tb.sv */
`default_nettype none

module matmul_tb;

    localparam int RESET_CYCLES = 10;
    localparam int GROUP_CYCLES = array_pkg::SLICES;
    // 27 cells plus one cycle that shows the drained queue
    localparam int READOUT_CYCLES = array_pkg::CELLS + 1;
    localparam int TAIL_CYCLES = GROUP_CYCLES + READOUT_CYCLES;
    localparam int DECODE_CYCLES = 256;
    localparam int HALVING_GROUPS = 20;
    localparam int BURST_GROUPS = 8;
    localparam int RANDOM_GROUPS = 40;
    localparam int WRAP_GROUPS = 640;
    localparam int DATA_GROUPS = 1 + HALVING_GROUPS + 2 * BURST_GROUPS + RANDOM_GROUPS
                                 + WRAP_GROUPS;
    // seven bursts end in an idle group and a readout
    localparam int CYCLE_LIMIT = RESET_CYCLES + DECODE_CYCLES + GROUP_CYCLES * DATA_GROUPS
                                 + 7 * TAIL_CYCLES + 100;

    logic clk;
    logic reset;
    weight_pkg::packed_weights_t weights_in;
    array_pkg::activation_t activation_in;
    logic read_out;
    array_pkg::result_t result;

    // reference accumulators, row-major like the DUT queue
    array_pkg::acc_t acc_model [array_pkg::CELLS];
    logic [31:0] rng_state;
    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;
    int test_count = 0;
    int mark_checks = 0;
    int mark_errors = 0;

    matmul_top uut (
        .clk           (clk),
        .reset         (reset),
        .weights_in    (weights_in),
        .activation_in (activation_in),
        .read_out      (read_out),
        .result        (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles before all tests finished", cycle_count);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int random_below(input int limit);
        return int'(next_random() % 32'(limit));
    endfunction

    // weight value in units of one half, from the base 7/7/5 digits
    function automatic int weight_halves(input int code, input int lane);
        int digit;
        if (code >= weight_pkg::CODE_LIMIT) begin
            return 0;
        end
        if (lane == 0) begin
            digit = code / (weight_pkg::LOW_BASE * weight_pkg::HIGH_BASE);
        end else if (lane == 1) begin
            digit = (code / weight_pkg::LOW_BASE) % weight_pkg::HIGH_BASE;
        end else begin
            digit = code % weight_pkg::LOW_BASE;
        end
        if (lane == 2) begin
            case (digit)
                0: return 0;
                1: return 2;
                2: return 4;
                3: return -2;
                default: return -4;
            endcase
        end
        case (digit)
            0: return 0;
            1: return 1;
            2: return 2;
            3: return 4;
            4: return -1;
            5: return -2;
            default: return -4;
        endcase
    endfunction

    function automatic weight_pkg::weight_op_t expected_op(input int halves);
        weight_pkg::weight_op_t op;
        op.zero = halves == 0;
        op.negate = halves < 0;
        op.double_it = halves == 4 || halves == -4;
        op.halve = halves == 1 || halves == -1;
        return op;
    endfunction

    // a half weight takes the floor of act/2 before the sign is applied
    function automatic int contribution(input int halves, input int act);
        int half_act;
        int magnitude;
        int term;
        half_act = act / 2;
        if (act < 0 && act % 2 != 0) begin
            half_act = half_act - 1;
        end
        magnitude = halves < 0 ? -halves : halves;
        if (magnitude == 1) begin
            term = half_act;
        end else begin
            term = act * magnitude / 2;
        end
        return halves < 0 ? -term : term;
    endfunction

    task automatic check_result(input array_pkg::result_t got,
                                input array_pkg::result_t expected, input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL %0t: %s gave result %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic check_lanes(input weight_pkg::weight_lane_t got,
                               input weight_pkg::weight_lane_t expected, input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL %0t: %s decoded to %h, expected %h", $time, what, got, expected);
        end
    endtask

    // one byte per slice, byte k feeds rows 3k..3k+2 and column k
    task automatic drive_group(input int codes [array_pkg::SLICES],
                               input int acts [array_pkg::SLICES]);
        int halves;
        int idx;
        for (int k = 0; k < array_pkg::SLICES; k++) begin
            weights_in = weight_pkg::packed_weights_t'(codes[k]);
            activation_in = array_pkg::activation_t'(acts[k]);
            @(posedge clk);
            #1;
        end
        for (int r = 0; r < array_pkg::ROWS; r++) begin
            halves = weight_halves(codes[r / weight_pkg::LANES], r % weight_pkg::LANES);
            for (int c = 0; c < array_pkg::COLS; c++) begin
                idx = r * array_pkg::COLS + c;
                acc_model[idx] = acc_model[idx] + array_pkg::acc_t'(contribution(halves, acts[c]));
            end
        end
    endtask

    // idle group lets the last group land, then read out and compare every cell
    task automatic finish_burst();
        int zeros [array_pkg::SLICES];
        array_pkg::result_t expected;
        zeros = '{0, 0, 0};
        drive_group(zeros, zeros);
        read_out = 1'b1;
        @(posedge clk);
        #1;
        read_out = 1'b0;
        for (int k = 0; k < READOUT_CYCLES; k++) begin
            if (k > 0) begin
                @(posedge clk);
                #1;
            end
            if (k < array_pkg::CELLS) begin
                expected = acc_model[k][16:9];
            end else begin
                expected = '0;
            end
            check_result(result, expected, $sformatf("readout cell %0d", k));
        end
        for (int k = 0; k < array_pkg::CELLS; k++) begin
            acc_model[k] = '0;
        end
    endtask

    task automatic random_burst(input int groups);
        int codes [array_pkg::SLICES];
        int acts [array_pkg::SLICES];
        for (int g = 0; g < groups; g++) begin
            for (int k = 0; k < array_pkg::SLICES; k++) begin
                codes[k] = random_below(256);
                acts[k] = random_below(256) - 128;
            end
            drive_group(codes, acts);
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("%-24s %0d checks, %0d errors", name, check_count - mark_checks,
                 error_count - mark_errors);
        mark_checks = check_count;
        mark_errors = error_count;
    endtask

    task automatic test_reset_readout();
        finish_burst();
        end_test("reset readout");
    endtask

    task automatic test_decode_all_codes();
        weight_pkg::weight_lane_t expected;
        for (int code = 0; code < 256; code++) begin
            weights_in = weight_pkg::packed_weights_t'(code);
            activation_in = '0;
            #1;
            for (int lane = 0; lane < weight_pkg::LANES; lane++) begin
                expected[lane] = expected_op(weight_halves(code, lane));
            end
            check_lanes(uut.lanes, expected, $sformatf("code %0d", code));
            @(posedge clk);
            #1;
        end
        finish_burst();
        end_test("decode all codes");
    endtask

    task automatic test_large_group();
        int codes [array_pkg::SLICES];
        int acts [array_pkg::SLICES];
        // all weights are +2 or -2
        codes = '{137, 229, 244};
        acts = '{127, -127, 127};
        drive_group(codes, acts);
        finish_burst();
        end_test("large single group");
    endtask

    task automatic test_halving();
        int codes [array_pkg::SLICES];
        int acts [array_pkg::SLICES];
        int block_sum [array_pkg::SLICES];
        int digit;
        for (int g = 0; g < HALVING_GROUPS; g++) begin
            // three groups at +0.5, then one at -0.5 whose activation is their sum
            // the exact block total is zero, so only the per-halving floor moves a cell
            digit = (g % 4 == 3) ? 4 : 1;
            for (int k = 0; k < array_pkg::SLICES; k++) begin
                if (g % 4 == 0) begin
                    block_sum[k] = 0;
                end
                codes[k] = digit * 35 + digit * 5 + random_below(5);
                if (g % 4 == 3) begin
                    acts[k] = block_sum[k];
                end else begin
                    acts[k] = -(2 * random_below(21) + 1);
                    block_sum[k] = block_sum[k] + acts[k];
                end
            end
            drive_group(codes, acts);
        end
        finish_burst();
        end_test("halving accumulation");
    endtask

    task automatic test_clear_between_bursts();
        random_burst(BURST_GROUPS);
        finish_burst();
        random_burst(BURST_GROUPS);
        finish_burst();
        end_test("clear on readout");
    endtask

    task automatic test_random_with_wrap();
        int codes [array_pkg::SLICES];
        int acts [array_pkg::SLICES];
        // code 122 is +2 on every lane, enough groups push all cells past 2^17
        codes = '{122, 122, 122};
        acts = '{127, 127, 127};
        random_burst(RANDOM_GROUPS / 2);
        for (int g = 0; g < WRAP_GROUPS; g++) begin
            drive_group(codes, acts);
        end
        random_burst(RANDOM_GROUPS / 2);
        finish_burst();
        end_test("random with wrap");
    endtask

    initial begin
        reset = 1'b1;
        read_out = 1'b0;
        weights_in = '0;
        activation_in = '0;
        rng_state = 32'd28;
        for (int k = 0; k < array_pkg::CELLS; k++) begin
            acc_model[k] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        test_reset_readout();
        test_decode_all_codes();
        test_large_group();
        test_halving();
        test_clear_between_bursts();
        test_random_with_wrap();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/array_pkg.sv */
`default_nettype none

package array_pkg;

    // one operand group is collected over SLICES input cycles
    localparam int SLICES = 3;
    localparam int ROWS = weight_pkg::LANES * SLICES;
    localparam int COLS = SLICES;
    localparam int CELLS = ROWS * COLS;

    localparam int ACT_W = 8;
    localparam int ACC_W = 18;
    localparam int RESULT_W = 8;

    // the output byte starts at this accumulator bit
    localparam int RESULT_SHIFT = 9;

    typedef logic signed [ACT_W-1:0] activation_t;
    // one bit wider than an activation so doubling cannot overflow
    typedef logic signed [ACT_W:0] addend_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [RESULT_W-1:0] result_t;
    typedef logic [1:0] slice_count_t;

    // weights for every row and activations for every column
    typedef struct packed {
        weight_pkg::weight_op_t [ROWS-1:0] ops;
        activation_t [COLS-1:0] acts;
    } operand_group_t;

endpackage

`default_nettype wire

/* logic/mac_array.sv */
`default_nettype none

module mac_array (
    input  logic clk,
    input  logic reset,
    input  logic clear,
    input  array_pkg::operand_group_t group,
    input  logic group_valid,
    output array_pkg::acc_t [array_pkg::CELLS-1:0] acc_next
);

    array_pkg::acc_t [array_pkg::CELLS-1:0] acc_q;

    // cell index is row * COLS + column
    for (genvar r = 0; r < array_pkg::ROWS; r++) begin : g_row
        for (genvar c = 0; c < array_pkg::COLS; c++) begin : g_col
            weight_pkg::weight_op_t op;
            array_pkg::addend_t act_ext;
            array_pkg::addend_t addend;
            array_pkg::acc_t sum;
            array_pkg::acc_t diff;

            assign op = group.ops[r];

            // sign extend before shifting, halving rounds toward minus infinity
            assign act_ext = array_pkg::addend_t'($signed(group.acts[c]));
            assign addend = op.double_it ? act_ext <<< 1 :
                            op.halve     ? act_ext >>> 1 :
                                           act_ext;

            // 18 bit wrap around on overflow
            assign sum = acc_q[r*array_pkg::COLS + c] + array_pkg::acc_t'(addend);
            assign diff = acc_q[r*array_pkg::COLS + c] - array_pkg::acc_t'(addend);

            // hold unless a group is presented with a nonzero weight
            assign acc_next[r*array_pkg::COLS + c] =
                (!group_valid || op.zero) ? acc_q[r*array_pkg::COLS + c] :
                op.negate                 ? diff :
                                            sum;
        end
    end

    // the readout snapshot takes acc_next, so clearing here loses nothing
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_next;
        end
    end

endmodule

`default_nettype wire

/* logic/matmul_top.sv */
`default_nettype none

module matmul_top (
    input  logic clk,
    input  logic reset,
    input  weight_pkg::packed_weights_t weights_in,
    input  array_pkg::activation_t activation_in,
    input  logic read_out,
    output array_pkg::result_t result
);

    weight_pkg::weight_lane_t lanes;
    array_pkg::operand_group_t group;
    logic group_valid;
    array_pkg::acc_t [array_pkg::CELLS-1:0] acc_next;

    // decode stage
    weight_decoder u_decoder (
        .code  (weights_in),
        .lanes (lanes)
    );

    operand_buffer u_buffer (
        .clk         (clk),
        .reset       (reset),
        .read_out    (read_out),
        .lanes       (lanes),
        .activation  (activation_in),
        .group       (group),
        .group_valid (group_valid)
    );

    // execute stage, cleared by the same pulse that snapshots it
    mac_array u_array (
        .clk         (clk),
        .reset       (reset),
        .clear       (read_out),
        .group       (group),
        .group_valid (group_valid),
        .acc_next    (acc_next)
    );

    // result stage
    result_queue u_queue (
        .clk      (clk),
        .reset    (reset),
        .load     (read_out),
        .acc_next (acc_next),
        .result   (result)
    );

endmodule

`default_nettype wire

/* logic/operand_buffer.sv */
`default_nettype none

module operand_buffer (
    input  logic clk,
    input  logic reset,
    input  logic read_out,
    input  weight_pkg::weight_lane_t lanes,
    input  array_pkg::activation_t activation,
    output array_pkg::operand_group_t group,
    output logic group_valid
);

    array_pkg::slice_count_t slice_q;
    array_pkg::operand_group_t next_q;
    array_pkg::operand_group_t shifted;
    logic last_slice;

    assign last_slice = slice_q == array_pkg::slice_count_t'(array_pkg::SLICES - 1);

    // newest byte enters at the top rows and column, older slices move down
    // so after a full group slice k sits at rows 3k..3k+2 and column k
    assign shifted.ops = {lanes, next_q.ops[array_pkg::ROWS-1:weight_pkg::LANES]};
    assign shifted.acts = {activation, next_q.acts[array_pkg::COLS-1:1]};

    // slice counter, restarted by a readout
    always_ff @(posedge clk) begin
        if (reset || read_out) begin
            slice_q <= '0;
        end else if (last_slice) begin
            slice_q <= '0;
        end else begin
            slice_q <= slice_q + 1'b1;
        end
    end

    // one cycle level, the array consumes the group at the following edge
    always_ff @(posedge clk) begin
        if (reset || read_out) begin
            group_valid <= 1'b0;
        end else begin
            group_valid <= last_slice;
        end
    end

    // next group collects inputs, current group holds the completed one
    always_ff @(posedge clk) begin
        next_q <= shifted;
        if (last_slice) begin
            group <= shifted;
        end
    end

endmodule

`default_nettype wire

/* logic/result_queue.sv */
`default_nettype none

module result_queue (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  array_pkg::acc_t [array_pkg::CELLS-1:0] acc_next,
    output array_pkg::result_t result
);

    array_pkg::acc_t [array_pkg::CELLS-1:0] queue_q;

    // load snapshots every cell, otherwise the queue drains toward entry 0
    always_ff @(posedge clk) begin
        if (reset) begin
            queue_q <= '0;
        end else if (load) begin
            queue_q <= acc_next;
        end else begin
            queue_q <= {array_pkg::acc_t'(0), queue_q[array_pkg::CELLS-1:1]};
        end
    end

    // scale down by dropping the low RESULT_SHIFT bits
    assign result = queue_q[0][array_pkg::RESULT_W + array_pkg::RESULT_SHIFT - 1:
                               array_pkg::RESULT_SHIFT];

endmodule

`default_nettype wire

/* logic/weight_decoder.sv */
`default_nettype none

module weight_decoder (
    input  weight_pkg::packed_weights_t code,
    output weight_pkg::weight_lane_t lanes
);

    logic valid;
    logic [7:0] by_low;
    logic [2:0] top_digit;
    logic [2:0] mid_digit;
    logic [2:0] low_digit;

    // low digit 0..4 means 0, 1, 2, -1, -2
    function automatic weight_pkg::weight_op_t low_digit_op(input logic [2:0] digit);
        logic [2:0] magnitude;
        weight_pkg::weight_op_t op;
        op.negate = digit >= 3'd3;
        magnitude = op.negate ? digit - 3'd2 : digit;
        op.zero = digit == 3'd0;
        op.double_it = magnitude == 3'd2;
        op.halve = 1'b0;
        return op;
    endfunction

    // middle and top digits 0..6 mean 0, 0.5, 1, 2, -0.5, -1, -2
    function automatic weight_pkg::weight_op_t high_digit_op(input logic [2:0] digit);
        logic [2:0] magnitude;
        weight_pkg::weight_op_t op;
        op.negate = digit >= 3'd4;
        magnitude = op.negate ? digit - 3'd3 : digit;
        op.zero = digit == 3'd0;
        op.halve = magnitude == 3'd1;
        op.double_it = magnitude == 3'd3;
        return op;
    endfunction

    assign valid = code < 8'(weight_pkg::CODE_LIMIT);

    // peel off the radix 5 digit first, then the two radix 7 digits
    assign by_low = code / 8'(weight_pkg::LOW_BASE);

    // an invalid code reads as all zero digits, so every lane holds
    assign low_digit = valid ? 3'(code % 8'(weight_pkg::LOW_BASE)) : 3'd0;
    assign mid_digit = valid ? 3'(by_low % 8'(weight_pkg::HIGH_BASE)) : 3'd0;
    assign top_digit = valid ? 3'(by_low / 8'(weight_pkg::HIGH_BASE)) : 3'd0;

    assign lanes[0] = high_digit_op(top_digit);
    assign lanes[1] = high_digit_op(mid_digit);
    assign lanes[2] = low_digit_op(low_digit);

endmodule

`default_nettype wire

/* logic/weight_pkg.sv */
`default_nettype none

package weight_pkg;

    // three weights share one byte, radix 7 * 7 * 5
    localparam int LANES = 3;
    localparam int LOW_BASE = 5;
    localparam int HIGH_BASE = 7;

    // codes from here up carry no weights
    localparam int CODE_LIMIT = HIGH_BASE * HIGH_BASE * LOW_BASE;

    typedef logic [7:0] packed_weights_t;

    // one weight as a set of operations on the activation
    // zero      adds nothing
    // negate    subtracts instead of adding
    // double_it multiplies by 2
    // halve     multiplies by 0.5, rounded down
    typedef struct packed {
        logic zero;
        logic negate;
        logic double_it;
        logic halve;
    } weight_op_t;

    // lane 0 top digit, lane 1 middle digit, lane 2 low digit
    typedef weight_op_t [LANES-1:0] weight_lane_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run matmul_tb with Verilator, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f src.f --top-module matmul_tb -o matmul_sim \
    && ./obj_dir/matmul_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q 'Test failures found' sim.log && { echo "simulation FAILED"; exit 1; }
grep -q 'All tests passed!' sim.log || { echo "no pass message in log"; exit 1; }
echo "simulation passed"
exit 0

/* src.f */
logic/weight_pkg.sv
logic/array_pkg.sv
logic/weight_decoder.sv
logic/operand_buffer.sv
logic/mac_array.sv
logic/result_queue.sv
logic/matmul_top.sv
bench/matmul_tb.sv
